// ==== hw/board_pkg.sv ====
`default_nettype none

// ===========================================================================
// Board level definitions for the host command port and the front panel
// ===========================================================================
package board_pkg;

	localparam int host_w = 16;

	// Word as sampled from the host bus
	typedef logic [host_w-1:0] host_word_t;

	// Command opcodes, taken from the low byte of the first word
	typedef enum logic [7:0] {
		op_cfg = 8'h01,
		op_led = 8'h25,
		op_vol = 8'h26
	} host_op_e;

	// Composite sync enable in the configuration word
	localparam int cfg_csync_bit = 3;

	// Bit 4 mutes, bits 3..0 are the attenuation shift
	typedef logic [4:0] vol_t;

	// Button sampling divisor and number of equal samples per change
	localparam int deb_tick_default = 100000;
	localparam int deb_depth = 8;

endpackage

`default_nettype wire

// ==== hw/av_pkg.sv ====
`default_nettype none

// ===========================================================================
// Audio and video definitions shared by the mixer and the sync fixer
// ===========================================================================
package av_pkg;

	localparam int sample_w = 16;
	localparam int sync_cnt_w = 32;

	// One audio sample, signedness chosen at run time by audio_s
	typedef logic [sample_w-1:0] sample_t;

	// Amount of the opposite channel mixed into each output
	typedef enum logic [1:0] {
		mix_none = 2'd0,
		mix_eighth = 2'd1,
		mix_quarter = 2'd2,
		mix_half = 2'd3
	} mix_e;

	// Cycle count of one sync phase
	typedef logic [sync_cnt_w-1:0] sync_cnt_t;

	// Longest line at the board clock fits easily in 32 bits

endpackage

`default_nettype wire

// ==== hw/cfg_if.sv ====
`default_nettype none

// Decoded host configuration, written by the command port
interface cfg_if;
	import board_pkg::*;

	// Per bit takeover of the board LEDs
	logic [7:0] led_overtake;
	logic [7:0] led_state;

	// Audio attenuation and mute
	vol_t vol;

	// Composite sync on the VGA hsync pin
	logic csync;

	modport src (output led_overtake, output led_state, output vol, output csync);
	modport dst (input led_overtake, input led_state, input vol, input csync);

endinterface

`default_nettype wire

// ==== hw/host_cmd.sv ====
`default_nettype none

module host_cmd (
	input wire clk,
	input wire resetd,
	input board_pkg::host_word_t io_din,
	input wire io_clk,
	input wire io_uio,
	cfg_if.src cfg
);
	import board_pkg::*;

	// =======================================================================
	// Input synchronizer and strobe detection
	// =======================================================================

	host_word_t din_s1;
	host_word_t din_s2;
	host_word_t word_q;
	logic clk_s1;
	logic clk_s2;
	logic clk_s3;
	logic uio_s1;
	logic uio_s2;
	logic strobe_q;

	// Host data word pipeline
	always_ff @(posedge clk) begin
		din_s1 <= io_din;
		din_s2 <= din_s1;
		// Extra stage lines the word up with the strobe
		word_q <= din_s2;
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			clk_s1 <= 1'b0;
			clk_s2 <= 1'b0;
			clk_s3 <= 1'b0;
			uio_s1 <= 1'b0;
			uio_s2 <= 1'b0;
			strobe_q <= 1'b0;
		end else begin
			clk_s1 <= io_clk;
			clk_s2 <= clk_s1;
			clk_s3 <= clk_s2;
			uio_s1 <= io_uio;
			uio_s2 <= uio_s1;
			// Rising edge of the synchronized io_clk
			strobe_q <= clk_s2 & ~clk_s3;
		end
	end

	// =======================================================================
	// Command decode
	// =======================================================================

	logic has_cmd;
	host_op_e cmd;

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cfg.led_overtake <= '0;
			cfg.led_state <= '0;
			cfg.vol <= '0;
			cfg.csync <= 1'b0;
		end else if (!uio_s2) begin
			has_cmd <= 1'b0;
		end else if (strobe_q) begin
			if (!has_cmd) begin
				// First word after io_uio rises carries the opcode
				has_cmd <= 1'b1;
				cmd <= host_op_e'(word_q[7:0]);
			end else begin
				case (cmd)
					op_cfg: cfg.csync <= word_q[cfg_csync_bit];
					op_led: {cfg.led_overtake, cfg.led_state} <= word_q;
					op_vol: cfg.vol <= word_q[4:0];
					default: ;
				endcase
			end
		end
	end

	// Configuration only moves inside a framed command
	a_cfg_framed: assert property (@(posedge clk) disable iff (resetd)
		!uio_s2 |=> $stable({cfg.led_overtake, cfg.led_state, cfg.vol, cfg.csync}));

endmodule

`default_nettype wire

// ==== hw/front_panel.sv ====
`default_nettype none

module front_panel #(
	parameter int deb_tick = board_pkg::deb_tick_default
) (
	input wire clk,
	input wire resetd,
	input wire btn_user_n,
	input wire btn_osd_n,
	input wire [1:0] key,
	input wire led_user,
	input wire [1:0] led_power,
	input wire [1:0] led_disk,
	cfg_if.dst cfg,
	output logic btn_user,
	output logic btn_osd,
	output logic [7:0] led,
	output logic led_user_on,
	output logic led_power_on,
	output logic led_hdd_on
);
	import board_pkg::*;

	// =======================================================================
	// Button debounce
	// =======================================================================

	int unsigned div;
	logic tick;
	logic [deb_depth-1:0] deb_user;
	logic [deb_depth-1:0] deb_osd;
	logic [deb_depth-1:0] user_nxt;
	logic [deb_depth-1:0] osd_nxt;

	assign tick = (div == deb_tick);

	// Board button and matching key are both active low
	assign user_nxt = {deb_user[deb_depth-2:0], ~(btn_user_n & key[1])};
	assign osd_nxt = {deb_osd[deb_depth-2:0], ~(btn_osd_n & key[0])};

	always_ff @(posedge clk) begin
		if (resetd) begin
			div <= 0;
			deb_user <= '0;
			deb_osd <= '0;
			btn_user <= 1'b0;
			btn_osd <= 1'b0;
		end else begin
			div <= tick ? 0 : div + 1;
			if (tick) begin
				deb_user <= user_nxt;
				deb_osd <= osd_nxt;
				// State only flips on a full run of equal samples
				if (&user_nxt) btn_user <= 1'b1;
				if (~|user_nxt) btn_user <= 1'b0;
				if (&osd_nxt) btn_osd <= 1'b1;
				if (~|osd_nxt) btn_osd <= 1'b0;
			end
		end
	end

	a_btn_on_tick: assert property (@(posedge clk) disable iff (resetd)
		!tick |=> $stable(btn_user));

	// =======================================================================
	// LEDs
	// =======================================================================

	assign led_power_on = led_power[1] ? ~led_power[0] : 1'b0;
	// Disk LED level is active low in both modes
	assign led_hdd_on = ~led_disk[0];
	assign led_user_on = led_user;

	assign led = (cfg.led_overtake & cfg.led_state) |
		(~cfg.led_overtake & {3'b000, led_power_on, 1'b0, led_hdd_on, 1'b0, led_user_on});

endmodule

`default_nettype wire

// ==== hw/audio_mix.sv ====
`default_nettype none

module audio_mix (
	input wire clk,
	input wire resetd,
	input av_pkg::sample_t audio_ls,
	input av_pkg::sample_t audio_rs,
	input wire audio_s,
	input av_pkg::mix_e audio_mix,
	cfg_if.dst cfg,
	output av_pkg::sample_t audio_l,
	output av_pkg::sample_t audio_r
);
	import av_pkg::*;

	// Right shift that keeps the sign for signed samples
	function automatic sample_t shr(input sample_t x, input logic [3:0] k, input logic s);
		sample_t r;
		if (s)
			r = sample_t'($signed(x) >>> k);
		else
			r = x >> k;
		return r;
	endfunction

	// =======================================================================
	// Stage 1, cross mix
	// =======================================================================

	sample_t mix_l;
	sample_t mix_r;
	sample_t mix_lq;
	sample_t mix_rq;
	logic s_q;

	always_comb begin
		unique case (audio_mix)
			mix_none: begin
				mix_l = audio_ls;
				mix_r = audio_rs;
			end
			mix_eighth: begin
				mix_l = audio_ls - shr(audio_ls, 4'd3, audio_s) + shr(audio_rs, 4'd3, audio_s);
				mix_r = audio_rs - shr(audio_rs, 4'd3, audio_s) + shr(audio_ls, 4'd3, audio_s);
			end
			mix_quarter: begin
				mix_l = audio_ls - shr(audio_ls, 4'd2, audio_s) + shr(audio_rs, 4'd2, audio_s);
				mix_r = audio_rs - shr(audio_rs, 4'd2, audio_s) + shr(audio_ls, 4'd2, audio_s);
			end
			mix_half: begin
				// Mono
				mix_l = shr(audio_ls, 4'd1, audio_s) + shr(audio_rs, 4'd1, audio_s);
				mix_r = mix_l;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		mix_lq <= mix_l;
		mix_rq <= mix_r;
		s_q <= audio_s;
	end

	// =======================================================================
	// Stage 2, attenuation and mute
	// =======================================================================

	always_ff @(posedge clk) begin
		if (resetd || cfg.vol[4]) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= shr(mix_lq, cfg.vol[3:0], s_q);
			audio_r <= shr(mix_rq, cfg.vol[3:0], s_q);
		end
	end

	a_mute: assert property (@(posedge clk) disable iff (resetd)
		cfg.vol[4] |=> (audio_l == '0) && (audio_r == '0));

endmodule

`default_nettype wire

// ==== hw/sync_fix.sv ====
`default_nettype none

module sync_fix (
	input wire clk,
	input wire resetd,
	input wire sync_in,
	output logic sync_out
);
	import av_pkg::*;

	logic s1;
	logic s2;
	logic pol;
	sync_cnt_t cnt;
	sync_cnt_t high_len;
	sync_cnt_t low_len;

	always_ff @(posedge clk) begin
		if (resetd) begin
			{s1, s2} <= 2'b00;
			cnt <= '0;
			high_len <= '0;
			low_len <= '0;
			pol <= 1'b0;
		end else begin
			s1 <= sync_in;
			s2 <= s1;
			// Rise ends a low phase, fall ends a high phase
			if (~s2 & s1) low_len <= cnt;
			if (s2 & ~s1) high_len <= cnt;
			cnt <= (s2 != s1) ? '0 : cnt + 1'b1;
			pol <= high_len > low_len;
		end
	end

	// Short phase always comes out high
	assign sync_out = sync_in ^ pol;

endmodule

`default_nettype wire

// ==== hw/sys_top.sv ====
`default_nettype none

module sys_top #(
	parameter int deb_tick = board_pkg::deb_tick_default
) (
	input wire FPGA_CLK2_50,
	input wire resetd,
	input board_pkg::host_word_t io_din,
	input wire io_clk,
	input wire io_uio,
	input wire btn_user_n,
	input wire btn_osd_n,
	input wire [1:0] key,
	input wire led_user,
	input wire [1:0] led_power,
	input wire [1:0] led_disk,
	input av_pkg::sample_t audio_ls,
	input av_pkg::sample_t audio_rs,
	input wire audio_s,
	input av_pkg::mix_e audio_mix,
	input wire vs_in,
	input wire hs_in,
	output logic btn_user,
	output logic btn_osd,
	output logic [7:0] led,
	output logic led_user_on,
	output logic led_power_on,
	output logic led_hdd_on,
	output av_pkg::sample_t audio_l,
	output av_pkg::sample_t audio_r,
	output logic vga_vs,
	output logic vga_hs
);

	cfg_if cfg_bus ();

	host_cmd u_host_cmd (.clk(FPGA_CLK2_50), .resetd, .io_din, .io_clk, .io_uio, .cfg(cfg_bus));

	front_panel #(.deb_tick(deb_tick)) u_front_panel (
		.clk(FPGA_CLK2_50), .resetd, .btn_user_n, .btn_osd_n, .key,
		.led_user, .led_power, .led_disk, .cfg(cfg_bus),
		.btn_user, .btn_osd, .led, .led_user_on, .led_power_on, .led_hdd_on
	);

	audio_mix u_audio_mix (
		.clk(FPGA_CLK2_50), .resetd, .audio_ls, .audio_rs, .audio_s, .audio_mix,
		.cfg(cfg_bus), .audio_l, .audio_r
	);

	// =======================================================================
	// VGA sync
	// =======================================================================

	logic vs_fix;
	logic hs_fix;

	sync_fix sync_v (.clk(FPGA_CLK2_50), .resetd, .sync_in(vs_in), .sync_out(vs_fix));
	sync_fix sync_h (.clk(FPGA_CLK2_50), .resetd, .sync_in(hs_in), .sync_out(hs_fix));

	// Pins are active low, composite sync goes out on hsync
	assign vga_vs = cfg_bus.csync ? 1'b1 : ~vs_fix;
	assign vga_hs = cfg_bus.csync ? ~(vs_fix ^ hs_fix) : ~hs_fix;

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

// Free running clock and power-on reset for the testbench
module tb_clock #(
	parameter int period = 100,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic resetd
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Reset held for a fixed number of rising edges
	initial begin
		resetd = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#10 resetd = 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/tb_sys_top.sv ====
`default_nettype none

module tb_sys_top;
	timeunit 1ns;
	timeprecision 100ps;
	import board_pkg::*;
	import av_pkg::*;

	localparam int clk_period = 100;
	// Cycle budget of each test
	// Watchdog allows twice their sum
	localparam int t_led = 200;
	localparam int t_mix = 300;
	localparam int t_vol = 300;
	localparam int t_frame = 300;
	localparam int t_deb = 300;
	localparam int t_sync = 800;
	localparam int budget_cycles = t_led + t_mix + t_vol + t_frame + t_deb + t_sync;

	logic clk;
	logic resetd;
	host_word_t io_din;
	logic io_clk;
	logic io_uio;
	logic btn_user_n;
	logic btn_osd_n;
	logic [1:0] key;
	logic led_user;
	logic [1:0] led_power;
	logic [1:0] led_disk;
	sample_t audio_ls;
	sample_t audio_rs;
	logic audio_s;
	mix_e audio_mix;
	logic vs_in;
	logic hs_in;
	logic btn_user;
	logic btn_osd;
	logic [7:0] led;
	logic led_user_on;
	logic led_power_on;
	logic led_hdd_on;
	sample_t audio_l;
	sample_t audio_r;
	logic vga_vs;
	logic vga_hs;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic [31:0] lfsr_state = 32'h2f7e_aa57;
	logic csync_on = 1'b0;
	logic osd_guard = 1'b0;

	tb_clock #(.period(clk_period), .reset_cycles(4)) u_clock (.clk, .resetd);

	sys_top #(.deb_tick(3)) dut (
		.FPGA_CLK2_50(clk), .resetd, .io_din, .io_clk, .io_uio,
		.btn_user_n, .btn_osd_n, .key, .led_user, .led_power, .led_disk,
		.audio_ls, .audio_rs, .audio_s, .audio_mix, .vs_in, .hs_in,
		.btn_user, .btn_osd, .led, .led_user_on, .led_power_on, .led_hdd_on,
		.audio_l, .audio_r, .vga_vs, .vga_hs
	);

	// ========================================================================
	// Checks
	// ========================================================================

	a_csync_vs: assert property (@(posedge clk) disable iff (resetd) csync_on |-> vga_vs)
		else begin
			$display("[FAIL] vga_vs = %h, expected 1 in composite sync", vga_vs);
			errors++;
		end

	// Short OSD glitch must never reach the debounced state
	a_osd_glitch: assert property (@(posedge clk) disable iff (resetd) osd_guard |-> !btn_osd)
		else begin
			$display("[FAIL] btn_osd = %h, expected 0 during glitch", btn_osd);
			errors++;
		end

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
			else begin
				$display("[FAIL] %s = %h, expected %h", name, got, exp);
				errors++;
			end
	endtask

	task automatic report_fault(input string msg);
		$display("ERROR: %s", msg);
		errors++;
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		tests_run++;
		if (errors > errs_at_start) begin
			tests_failed++;
			$display("%s: failed with %0d wrong checks", name, errors - errs_at_start);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	// ========================================================================
	// Reference models and random source
	// ========================================================================

	// Fibonacci LFSR with taps 32 22 2 1
	// One step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [15:0] shift_right(input logic [15:0] v, input int n, input logic sgn);
		logic [15:0] r;
		r = v;
		for (int i = 0; i < n; i++)
			r = {sgn & r[15], r[15:1]};
		return r;
	endfunction

	function automatic logic [15:0] mix_expect(input logic [15:0] own, input logic [15:0] other,
		input logic [1:0] mode, input logic sgn);
		logic [15:0] r;
		case (mode)
			2'd1: r = own - shift_right(own, 3, sgn) + shift_right(other, 3, sgn);
			2'd2: r = own - shift_right(own, 2, sgn) + shift_right(other, 2, sgn);
			2'd3: r = shift_right(own, 1, sgn) + shift_right(other, 1, sgn);
			default: r = own;
		endcase
		return r;
	endfunction

	function automatic logic [7:0] led_expect(input logic u, input logic [1:0] p,
		input logic [1:0] d, input logic [7:0] ov, input logic [7:0] st);
		logic [7:0] def;
		def = 8'h00;
		def[4] = p[1] ? !p[0] : 1'b0;
		def[2] = !d[0];
		def[0] = u;
		return (ov & st) | (~ov & def);
	endfunction

	// ========================================================================
	// Stimulus helpers
	// ========================================================================

	task automatic step();
		@(posedge clk);
		#10;
	endtask

	task automatic host_word(input host_word_t w);
		step();
		io_din = w;
		step();
		io_clk = 1'b1;
		repeat (3) step();
		io_clk = 1'b0;
		repeat (2) step();
	endtask

	task automatic send_cmd(input host_op_e op, input host_word_t data);
		io_uio = 1'b1;
		repeat (3) step();
		host_word({8'h00, op});
		host_word(data);
		io_uio = 1'b0;
		repeat (3) step();
	endtask

	task automatic check_audio(input logic [15:0] l, input logic [15:0] r, input logic [1:0] m,
		input logic sgn, input int shift, input logic mute);
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		audio_ls = l;
		audio_rs = r;
		audio_s = sgn;
		audio_mix = mix_e'(m);
		repeat (2) step();
		exp_l = mute ? 16'h0000 : shift_right(mix_expect(l, r, m, sgn), shift, sgn);
		exp_r = mute ? 16'h0000 : shift_right(mix_expect(r, l, m, sgn), shift, sgn);
		check_hex("audio_l", 32'(audio_l), 32'(exp_l));
		check_hex("audio_r", 32'(audio_r), 32'(exp_r));
	endtask

	// ========================================================================
	// Tests
	// ========================================================================

	task automatic test_led();
		int e0;
		logic [31:0] rnd;
		e0 = errors;
		repeat (16) begin
			rnd = take_bits(5);
			led_user = rnd[0];
			led_power = rnd[2:1];
			led_disk = rnd[4:3];
			step();
			check_hex("led", 32'(led),
				32'(led_expect(led_user, led_power, led_disk, 8'h00, 8'h00)));
			check_hex("led_power_on", 32'(led_power_on), 32'(led_power[1] & !led_power[0]));
			check_hex("led_hdd_on", 32'(led_hdd_on), 32'(!led_disk[0]));
			check_hex("led_user_on", 32'(led_user_on), 32'(led_user));
		end
		rnd = take_bits(16);
		// Data word strobed by hand to see the 4 cycle write latency
		io_uio = 1'b1;
		repeat (3) step();
		host_word({8'h00, op_led});
		step();
		io_din = rnd[15:0];
		step();
		io_clk = 1'b1;
		repeat (3) step();
		check_hex("led", 32'(led),
			32'(led_expect(led_user, led_power, led_disk, 8'h00, 8'h00)));
		step();
		check_hex("led", 32'(led),
			32'(led_expect(led_user, led_power, led_disk, rnd[15:8], rnd[7:0])));
		io_clk = 1'b0;
		repeat (2) step();
		io_uio = 1'b0;
		repeat (3) step();
		send_cmd(op_led, 16'h0000);
		end_test("led composition", e0);
	endtask

	task automatic test_mix();
		int e0;
		logic [31:0] rnd;
		e0 = errors;
		for (int m = 0; m < 4; m++) begin
			for (int s = 0; s < 2; s++) begin
				repeat (4) begin
					rnd = take_bits(32);
					check_audio(rnd[31:16], rnd[15:0], 2'(m), 1'(s), 0, 1'b0);
				end
			end
		end
		end_test("mix and signedness", e0);
	endtask

	task automatic test_volume();
		int e0;
		logic [31:0] rnd;
		logic [31:0] ctl;
		e0 = errors;
		for (int n = 1; n < 16; n = n * 2 + 1) begin
			send_cmd(op_vol, 16'(n));
			repeat (3) begin
				rnd = take_bits(32);
				ctl = take_bits(3);
				check_audio(rnd[31:16], rnd[15:0], ctl[1:0], ctl[2], n, 1'b0);
			end
		end
		send_cmd(op_vol, 16'h0012);
		repeat (3) begin
			rnd = take_bits(32);
			ctl = take_bits(3);
			check_audio(rnd[31:16], rnd[15:0], ctl[1:0], ctl[2], 2, 1'b1);
		end
		send_cmd(op_vol, 16'h0000);
		end_test("volume and mute", e0);
	endtask

	task automatic test_framing();
		int e0;
		e0 = errors;
		led_user = 1'b0;
		led_power = 2'b00;
		led_disk = 2'b01;
		send_cmd(op_led, 16'hffa5);
		check_hex("led", 32'(led), 32'h a5);
		// Data strobes with io_uio low
		host_word({8'h00, op_led});
		host_word(16'hff00);
		check_hex("led", 32'(led), 32'h a5);
		// Unknown opcode
		send_cmd(host_op_e'(8'h77), 16'hff5a);
		check_hex("led", 32'(led), 32'h a5);
		// Second data word overwrites the first
		io_uio = 1'b1;
		repeat (3) step();
		host_word({8'h00, op_led});
		host_word(16'hff3c);
		host_word(16'hffc3);
		io_uio = 1'b0;
		repeat (3) step();
		check_hex("led", 32'(led), 32'h c3);
		send_cmd(op_led, 16'h0000);
		end_test("command framing", e0);
	endtask

	task automatic test_debounce();
		int e0;
		int n;
		e0 = errors;
		// One tick every 4 cycles with deb_tick 3
		btn_user_n = 1'b0;
		n = 0;
		while (!btn_user && n < 36) begin
			step();
			n++;
		end
		if (!btn_user)
			report_fault("btn_user was not set within 9 debounce ticks");
		btn_user_n = 1'b1;
		n = 0;
		while (btn_user && n < 36) begin
			step();
			n++;
		end
		if (btn_user)
			report_fault("btn_user was not cleared within 9 debounce ticks");
		osd_guard = 1'b1;
		btn_osd_n = 1'b0;
		repeat (24) step();
		btn_osd_n = 1'b1;
		repeat (48) step();
		osd_guard = 1'b0;
		end_test("button debounce", e0);
	endtask

	// hsync period 16 cycles with a 3 cycle pulse
	// vsync period 48 cycles with a 6 cycle pulse
	task automatic run_sync(input logic active_high, input logic comp, input int periods);
		logic hs_act;
		logic vs_act;
		hs_act = 1'b0;
		vs_act = 1'b0;
		for (int c = 0; c < periods * 48; c++) begin
			step();
			if (c >= (periods - 1) * 48) begin
				if (comp) begin
					check_hex("vga_hs", 32'(vga_hs), 32'(!(hs_act ^ vs_act)));
				end else begin
					check_hex("vga_hs", 32'(vga_hs), 32'(!hs_act));
					check_hex("vga_vs", 32'(vga_vs), 32'(!vs_act));
				end
			end
			hs_act = (c % 16) < 3;
			vs_act = (c % 48) < 6;
			hs_in = active_high ? hs_act : !hs_act;
			vs_in = active_high ? vs_act : !vs_act;
		end
	endtask

	task automatic test_sync();
		int e0;
		e0 = errors;
		run_sync(1'b0, 1'b0, 3);
		run_sync(1'b1, 1'b0, 3);
		send_cmd(op_cfg, 16'h0001 << cfg_csync_bit);
		csync_on = 1'b1;
		run_sync(1'b0, 1'b1, 3);
		end_test("sync polarity and composite sync", e0);
	endtask

	// ========================================================================
	// Sequence and watchdog
	// ========================================================================

	initial begin
		io_din = '0;
		io_clk = 1'b0;
		io_uio = 1'b0;
		btn_user_n = 1'b1;
		btn_osd_n = 1'b1;
		key = 2'b11;
		led_user = 1'b0;
		led_power = 2'b00;
		led_disk = 2'b00;
		audio_ls = '0;
		audio_rs = '0;
		audio_s = 1'b0;
		audio_mix = mix_none;
		vs_in = 1'b1;
		hs_in = 1'b1;
		wait (resetd === 1'b0);
		step();
		test_led();
		test_mix();
		test_volume();
		test_framing();
		test_debounce();
		test_sync();
		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		#(2 * budget_cycles * clk_period);
		$display("ERROR: watchdog expired before the tests completed");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/board_pkg.sv
hw/av_pkg.sv
hw/cfg_if.sv
hw/host_cmd.sv
hw/front_panel.sv
hw/audio_mix.sv
hw/sync_fix.sv
hw/sys_top.sv
test/tb_clock.sv
test/tb_sys_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
	--top-module tb_sys_top --Mdir obj_dir -o tb_sys_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sys_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
